//--- flist.f
hdl/tk1_pkg.sv
hdl/tk1_regs.sv
hdl/tk1_mode_ctrl.sv
hdl/tk1_exec_monitor.sv
hdl/tk1_trap_led.sv
hdl/tk1_core.sv
test/tb_tk1.sv

//--- Makefile
SIM   = verilator
FLAGS = --binary --timing -j 0
TOP   = tb_tk1
FLIST = flist.f
BIN   = obj_dir/V$(TOP)
PASS  = ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# Exit status follows the pass line in the simulator output
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf obj_dir

//--- test/tb_tk1.sv
`timescale 1ns/1ps

module tb_tk1;

  import tk1_pkg::*;

  // Tests run for a few hundred cycles
  localparam int TIMEOUT_CYCLES = 5000;

  logic      clk = 1'b0;
  logic      reset_n;
  logic      cpu_trap;
  logic      cpu_valid;
  logic      cpu_instr;
  cpu_addr_t cpu_addr;
  logic      cs;
  logic      we;
  reg_addr_t address;
  word_t     write_data;
  word_t     read_data;
  logic      ready;
  logic      system_mode;
  logic      rw_locked;
  logic      force_trap;
  logic      system_reset;
  logic      gpio1;
  logic      gpio2;
  logic      gpio3;
  logic      gpio4;
  logic      led_r;
  logic      led_g;
  logic      led_b;

  // Register model indexed by register address
  word_t      model_mem [256];
  logic [1:0] gpio_in_m;
  logic       sys_mode_m;
  logic       locked_m;
  logic       rom_exec_m;
  logic       mon_en_m;
  logic       trap_m;

  int errors;
  int checks;
  int read_errors = 0;
  int read_checks = 0;
  int test_num;
  int errors_before;
  int cycles = 0;

  tk1_core i_dut (
    .clk          (clk),
    .reset_n      (reset_n),
    .cpu_trap     (cpu_trap),
    .cpu_valid    (cpu_valid),
    .cpu_instr    (cpu_instr),
    .cpu_addr     (cpu_addr),
    .system_mode  (system_mode),
    .rw_locked    (rw_locked),
    .force_trap   (force_trap),
    .system_reset (system_reset),
    .cs           (cs),
    .we           (we),
    .address      (address),
    .write_data   (write_data),
    .read_data    (read_data),
    .ready        (ready),
    .gpio1        (gpio1),
    .gpio2        (gpio2),
    .gpio3        (gpio3),
    .gpio4        (gpio4),
    .led_r        (led_r),
    .led_g        (led_g),
    .led_b        (led_b)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d cycles", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  // --------------------
  // Reference model
  // --------------------

  function automatic word_t ref_read(reg_addr_t a);
    if ((a >= ADDR_CDI_FIRST) && (a <= ADDR_CDI_LAST)) begin
      return model_mem[a];
    end
    case (a)
      ADDR_NAME0:            return TK1_NAME0;
      ADDR_NAME1:            return TK1_NAME1;
      ADDR_VERSION:          return TK1_VERSION;
      ADDR_SYSTEM_MODE_CTRL: return {32{sys_mode_m}};
      ADDR_GPIO:             return {model_mem[ADDR_GPIO][31:2], gpio_in_m};
      ADDR_CPU_MON_CTRL:     return {31'h0, mon_en_m};
      ADDR_LED, ADDR_APP_START, ADDR_APP_SIZE, ADDR_BLAKE2S, ADDR_SYSCALL,
      ADDR_CPU_MON_FIRST, ADDR_CPU_MON_LAST: return model_mem[a];
      default:               return '0;
    endcase
  endfunction

  // Expected trap for one valid access against the current model state
  function automatic logic trap_ref(cpu_addr_t a, logic instr);
    logic entry;
    entry = (a == model_mem[ADDR_SYSCALL]) || (a == model_mem[ADDR_BLAKE2S]);
    if ((a[31:30] == 2'b01) && (a[29:17] != '0)) begin
      return 1'b1;
    end
    if (!instr) begin
      return 1'b0;
    end
    if ((a >= FW_RAM_FIRST) && (a <= FW_RAM_LAST)) begin
      return 1'b1;
    end
    if (!rom_exec_m && !entry && (a <= FW_ROM_LAST)) begin
      return 1'b1;
    end
    if (mon_en_m && (a >= model_mem[ADDR_CPU_MON_FIRST]) &&
        (a <= model_mem[ADDR_CPU_MON_LAST])) begin
      return 1'b1;
    end
    return 1'b0;
  endfunction

  function automatic void model_write(reg_addr_t a, word_t d);
    if ((a >= ADDR_CDI_FIRST) && (a <= ADDR_CDI_LAST)) begin
      if (!locked_m) begin
        model_mem[a] = d;
      end
    end else begin
      case (a)
        ADDR_LED:  model_mem[a] = {29'h0, d[2:0]};
        ADDR_GPIO: model_mem[a] = {28'h0, d[GPIO4_BIT], d[GPIO3_BIT], 2'b00};
        ADDR_APP_START, ADDR_APP_SIZE, ADDR_BLAKE2S, ADDR_SYSCALL: begin
          if (!locked_m) begin
            model_mem[a] = d;
          end
        end
        ADDR_CPU_MON_FIRST, ADDR_CPU_MON_LAST: begin
          if (!mon_en_m) begin
            model_mem[a] = d;
          end
        end
        ADDR_CPU_MON_CTRL: mon_en_m = 1'b1;
        default: ;
      endcase
    end
  endfunction

  function automatic void model_fetch(cpu_addr_t a, logic instr);
    trap_m = trap_m | trap_ref(a, instr);
    if (instr) begin
      if (a > FW_ROM_LAST) begin
        sys_mode_m = 1'b1;
        rom_exec_m = 1'b0;
        locked_m   = 1'b1;
      end else begin
        if (a == model_mem[ADDR_SYSCALL]) begin
          sys_mode_m = 1'b0;
          rom_exec_m = 1'b1;
        end
        if (a == model_mem[ADDR_BLAKE2S]) begin
          rom_exec_m = 1'b1;
        end
      end
    end
  endfunction

  // CDI words and the monitor window keep their contents over reset
  function automatic void model_reset();
    model_mem[ADDR_LED]       = {29'h0, LED_RESET};
    model_mem[ADDR_GPIO]      = '0;
    model_mem[ADDR_APP_START] = '0;
    model_mem[ADDR_APP_SIZE]  = APP_SIZE_RESET;
    model_mem[ADDR_SYSCALL]   = ILLEGAL_ADDR;
    model_mem[ADDR_BLAKE2S]   = ILLEGAL_ADDR;
    sys_mode_m = 1'b0;
    locked_m   = 1'b0;
    rom_exec_m = 1'b1;
    mon_en_m   = 1'b0;
    trap_m     = 1'b0;
  endfunction

  // --------------------
  // Checks
  // --------------------

  // Every bus read is compared with the model
  always @(negedge clk) begin
    if (reset_n && cs && !we) begin
      read_checks++;
      if (read_data !== ref_read(address)) begin
        read_errors++;
        $display("mismatch at %0d ns: register %h reads %h, expected %h",
                 $time, address, read_data, ref_read(address));
      end
    end
    if (reset_n && (ready !== cs)) begin
      read_errors++;
      $display("mismatch at %0d ns: ready is %b while cs is %b", $time, ready, cs);
    end
  end

  task automatic check_value(string what, word_t got, word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(string what, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(string name);
    test_num++;
    $display("test %0d %s: %0d errors", test_num, name,
             errors + read_errors - errors_before);
    errors_before = errors + read_errors;
  endtask

  // --------------------
  // Stimulus
  // --------------------

  task automatic apply_reset();
    @(posedge clk);
    reset_n   <= 1'b0;
    cs        <= 1'b0;
    we        <= 1'b0;
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    model_reset();
  endtask

  task automatic write_reg(reg_addr_t a, word_t d);
    @(posedge clk);
    cs         <= 1'b1;
    we         <= 1'b1;
    address    <= a;
    write_data <= d;
    @(posedge clk);
    cs <= 1'b0;
    we <= 1'b0;
    model_write(a, d);
  endtask

  task automatic read_reg(reg_addr_t a);
    @(posedge clk);
    cs      <= 1'b1;
    we      <= 1'b0;
    address <= a;
    @(posedge clk);
    cs <= 1'b0;
  endtask

  // One CPU access followed by a check of the sticky outputs
  task automatic issue_fetch(cpu_addr_t a, logic instr);
    @(posedge clk);
    cpu_valid <= 1'b1;
    cpu_instr <= instr;
    cpu_addr  <= a;
    @(posedge clk);
    cpu_valid <= 1'b0;
    cpu_instr <= 1'b0;
    model_fetch(a, instr);
    @(negedge clk);
    check_bit("force_trap", force_trap, trap_m);
    check_bit("system_mode", system_mode, sys_mode_m);
    check_bit("rw_locked", rw_locked, locked_m);
  endtask

  // Writes and reads back app start, app size, entry points and CDI
  task automatic fill_protected();
    int i;
    write_reg(ADDR_APP_START, $urandom);
    write_reg(ADDR_APP_SIZE, $urandom);
    write_reg(ADDR_BLAKE2S, $urandom);
    write_reg(ADDR_SYSCALL, $urandom);
    for (i = 0; i < 8; i++) begin
      write_reg(ADDR_CDI_FIRST + reg_addr_t'(i), $urandom);
    end
    read_reg(ADDR_APP_START);
    read_reg(ADDR_APP_SIZE);
    read_reg(ADDR_BLAKE2S);
    read_reg(ADDR_SYSCALL);
    for (i = 0; i < 8; i++) begin
      read_reg(ADDR_CDI_FIRST + reg_addr_t'(i));
    end
  endtask

  initial begin
    word_t data;
    int    highs;
    int    i;
    void'($urandom(32'h3f1efdb4));
    reset_n    <= 1'b0;
    cpu_trap   <= 1'b0;
    cpu_valid  <= 1'b0;
    cpu_instr  <= 1'b0;
    cpu_addr   <= '0;
    cs         <= 1'b0;
    we         <= 1'b0;
    address    <= '0;
    write_data <= '0;
    gpio1      <= 1'b0;
    gpio2      <= 1'b0;
    for (i = 0; i < 256; i++) begin
      model_mem[i] = '0;
    end
    gpio_in_m     = 2'b00;
    errors        = 0;
    checks        = 0;
    test_num      = 0;
    errors_before = 0;
    apply_reset();

    read_reg(ADDR_NAME0);
    read_reg(ADDR_NAME1);
    read_reg(ADDR_VERSION);
    finish_test("identity");

    fill_protected();
    issue_fetch(32'h40000100, 1'b1);
    read_reg(ADDR_SYSTEM_MODE_CTRL);
    // The lock makes the model keep the old words
    fill_protected();
    data = $urandom;
    write_reg(ADDR_LED, data);
    read_reg(ADDR_LED);
    finish_test("registers and lock");

    data = $urandom;
    write_reg(ADDR_LED, data);
    @(negedge clk);
    check_value("led pins", {29'h0, led_r, led_g, led_b}, {29'h0, data[2:0]});
    data = $urandom;
    write_reg(ADDR_GPIO, data);
    @(negedge clk);
    check_bit("gpio3", gpio3, data[GPIO3_BIT]);
    check_bit("gpio4", gpio4, data[GPIO4_BIT]);
    for (i = 1; i < 4; i++) begin
      @(posedge clk);
      gpio1 <= i[0];
      gpio2 <= i[1];
      // The read below falls right after the second edge
      @(posedge clk);
      gpio_in_m = i[1:0];
      read_reg(ADDR_GPIO);
    end
    @(posedge clk);
    gpio1 <= 1'b0;
    gpio2 <= 1'b0;
    gpio_in_m = 2'b00;
    write_reg(ADDR_SYSTEM_RESET, $urandom);
    @(negedge clk);
    check_bit("system_reset after the write", system_reset, 1'b1);
    highs = 0;
    repeat (3) begin
      @(negedge clk);
      if (system_reset) begin
        highs++;
      end
    end
    check_value("system_reset extra high cycles", highs, 0);
    finish_test("led, gpio and reset strobe");

    apply_reset();
    issue_fetch(FW_RAM_FIRST + 32'h10, 1'b1);
    apply_reset();
    issue_fetch(32'h40020000, 1'b0);
    apply_reset();
    issue_fetch(32'h40000000, 1'b1);
    issue_fetch(32'h00000100, 1'b1);
    apply_reset();
    write_reg(ADDR_SYSCALL, 32'h00000200);
    issue_fetch(32'h40000000, 1'b1);
    issue_fetch(32'h00000200, 1'b1);
    check_bit("force_trap after syscall entry", force_trap, 1'b0);
    apply_reset();
    write_reg(ADDR_CPU_MON_FIRST, 32'h40001000);
    write_reg(ADDR_CPU_MON_LAST, 32'h40001fff);
    write_reg(ADDR_CPU_MON_CTRL, 32'h1);
    issue_fetch(32'h40000800, 1'b1);
    issue_fetch(32'h40001100, 1'b1);
    apply_reset();
    write_reg(ADDR_CPU_MON_FIRST, 32'h40002000);
    write_reg(ADDR_CPU_MON_LAST, 32'h40002fff);
    write_reg(ADDR_CPU_MON_CTRL, 32'h1);
    // This write must not move the frozen window
    write_reg(ADDR_CPU_MON_FIRST, 32'h40000000);
    read_reg(ADDR_CPU_MON_FIRST);
    read_reg(ADDR_CPU_MON_CTRL);
    issue_fetch(32'h40001100, 1'b1);
    finish_test("security monitor");

    @(posedge clk);
    cpu_trap <= 1'b1;
    apply_reset();
    // Red turns on one edge after reset
    @(posedge clk);
    @(negedge clk);
    check_value("trap led pins", {29'h0, led_r, led_g, led_b}, 32'h4);
    @(posedge clk);
    cpu_trap <= 1'b0;
    @(negedge clk);
    check_value("led pins", {29'h0, led_r, led_g, led_b}, model_mem[ADDR_LED]);
    finish_test("trap indication");

    $display("%0d tests, %0d checks, %0d errors", test_num,
             checks + read_checks, errors + read_errors);
    if ((errors + read_errors) == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- hdl/tk1_core.sv
`timescale 1ns/1ps

module tk1_core (
  input  logic                clk,
  input  logic                reset_n,

  input  logic                cpu_trap,
  input  logic                cpu_valid,
  input  logic                cpu_instr,
  input  tk1_pkg::cpu_addr_t  cpu_addr,

  output logic                system_mode,
  output logic                rw_locked,
  output logic                force_trap,
  output logic                system_reset,

  input  logic                cs,
  input  logic                we,
  input  tk1_pkg::reg_addr_t  address,
  input  tk1_pkg::word_t      write_data,
  output tk1_pkg::word_t      read_data,
  output logic                ready,

  input  logic                gpio1,
  input  logic                gpio2,
  output logic                gpio3,
  output logic                gpio4,

  output logic                led_r,
  output logic                led_g,
  output logic                led_b
);

  import tk1_pkg::*;

  cpu_addr_t syscall_addr;
  cpu_addr_t blake2s_addr;
  cpu_addr_t cpu_mon_first;
  cpu_addr_t cpu_mon_last;
  logic      cpu_mon_en;
  logic      rom_executable;
  logic      rom_entry;
  led_t      led_sw;

  // --------------------
  // Register bank
  // --------------------

  tk1_regs u_regs (
    .clk           (clk),
    .reset_n       (reset_n),
    .cs            (cs),
    .we            (we),
    .address       (address),
    .write_data    (write_data),
    .system_mode   (system_mode),
    .rw_locked     (rw_locked),
    .gpio1         (gpio1),
    .gpio2         (gpio2),
    .read_data     (read_data),
    .ready         (ready),
    .led_sw        (led_sw),
    .gpio3         (gpio3),
    .gpio4         (gpio4),
    .system_reset  (system_reset),
    .syscall_addr  (syscall_addr),
    .blake2s_addr  (blake2s_addr),
    .cpu_mon_en    (cpu_mon_en),
    .cpu_mon_first (cpu_mon_first),
    .cpu_mon_last  (cpu_mon_last)
  );

  // --------------------
  // Fetch path
  // --------------------

  tk1_mode_ctrl u_mode_ctrl (
    .clk            (clk),
    .reset_n        (reset_n),
    .cpu_valid      (cpu_valid),
    .cpu_instr      (cpu_instr),
    .cpu_addr       (cpu_addr),
    .syscall_addr   (syscall_addr),
    .blake2s_addr   (blake2s_addr),
    .system_mode    (system_mode),
    .rw_locked      (rw_locked),
    .rom_executable (rom_executable),
    .rom_entry      (rom_entry)
  );

  tk1_exec_monitor u_exec_monitor (
    .clk            (clk),
    .reset_n        (reset_n),
    .cpu_valid      (cpu_valid),
    .cpu_instr      (cpu_instr),
    .cpu_addr       (cpu_addr),
    .rom_executable (rom_executable),
    .rom_entry      (rom_entry),
    .cpu_mon_en     (cpu_mon_en),
    .cpu_mon_first  (cpu_mon_first),
    .cpu_mon_last   (cpu_mon_last),
    .force_trap     (force_trap)
  );

  tk1_trap_led u_trap_led (
    .clk      (clk),
    .reset_n  (reset_n),
    .cpu_trap (cpu_trap),
    .led_sw   (led_sw),
    .led_r    (led_r),
    .led_g    (led_g),
    .led_b    (led_b)
  );

endmodule

//--- hdl/tk1_trap_led.sv
`timescale 1ns/1ps

module tk1_trap_led (
  input  logic           clk,
  input  logic           reset_n,

  input  logic           cpu_trap,
  input  tk1_pkg::led_t  led_sw,

  output logic           led_r,
  output logic           led_g,
  output logic           led_b
);

  import tk1_pkg::*;

  blink_ctr_t blink_ctr;
  led_t       blink_led;
  led_t       led_sel;

  // --------------------
  // Blink generator
  // --------------------

  // Red toggles each time the counter wraps through zero
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      blink_ctr <= '0;
      blink_led <= '0;
    end else begin
      blink_ctr <= blink_ctr + 24'd1;
      if (blink_ctr == '0) begin
        blink_led <= blink_led ^ 3'b100;
      end
    end
  end

  // --------------------
  // Pin select
  // --------------------

  assign led_sel = cpu_trap ? blink_led : led_sw;

  assign led_r = led_sel[2];
  assign led_g = led_sel[1];
  assign led_b = led_sel[0];

endmodule

//--- hdl/tk1_exec_monitor.sv
`timescale 1ns/1ps

module tk1_exec_monitor (
  input  logic                clk,
  input  logic                reset_n,

  input  logic                cpu_valid,
  input  logic                cpu_instr,
  input  tk1_pkg::cpu_addr_t  cpu_addr,

  input  logic                rom_executable,
  input  logic                rom_entry,

  input  logic                cpu_mon_en,
  input  tk1_pkg::cpu_addr_t  cpu_mon_first,
  input  tk1_pkg::cpu_addr_t  cpu_mon_last,

  output logic                force_trap
);

  import tk1_pkg::*;

  logic fetch;
  logic ram_oob;
  logic fw_ram_fetch;
  logic rom_fetch_denied;
  logic mon_fetch;
  logic violation;

  assign fetch = cpu_valid && cpu_instr;

  // Any access to RAM above the physical 128 KiB
  assign ram_oob = cpu_valid && (cpu_addr[31:30] == 2'b01) && (|cpu_addr[29:17]);

  // FW RAM is data only
  assign fw_ram_fetch = fetch && (cpu_addr >= FW_RAM_FIRST) && (cpu_addr <= FW_RAM_LAST);

  // Locked ROM outside the entry points
  assign rom_fetch_denied = fetch && !rom_executable && !rom_entry &&
                            (cpu_addr <= FW_ROM_LAST);

  // Data-only window set up by the app
  assign mon_fetch = fetch && cpu_mon_en &&
                     (cpu_addr >= cpu_mon_first) && (cpu_addr <= cpu_mon_last);

  assign violation = ram_oob || fw_ram_fetch || rom_fetch_denied || mon_fetch;

  // Sticky until reset
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      force_trap <= 1'b0;
    end else if (violation) begin
      force_trap <= 1'b1;
    end
  end

endmodule

//--- hdl/tk1_mode_ctrl.sv
`timescale 1ns/1ps

module tk1_mode_ctrl (
  input  logic                clk,
  input  logic                reset_n,

  input  logic                cpu_valid,
  input  logic                cpu_instr,
  input  tk1_pkg::cpu_addr_t  cpu_addr,

  input  tk1_pkg::cpu_addr_t  syscall_addr,
  input  tk1_pkg::cpu_addr_t  blake2s_addr,

  output logic                system_mode,
  output logic                rw_locked,
  output logic                rom_executable,
  output logic                rom_entry
);

  import tk1_pkg::*;

  logic fetch;
  logic hit_syscall;
  logic hit_blake2s;
  logic above_rom;

  assign fetch       = cpu_valid && cpu_instr;
  // Entry points must be word aligned to match a fetch
  assign hit_syscall = fetch && (cpu_addr == syscall_addr);
  assign hit_blake2s = fetch && (cpu_addr == blake2s_addr);
  assign above_rom   = fetch && (cpu_addr > FW_ROM_LAST);

  // First instruction of an entry point is allowed from locked ROM
  assign rom_entry = hit_syscall || hit_blake2s;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      system_mode    <= 1'b0;
      rom_executable <= 1'b1;
      rw_locked      <= 1'b0;
    end else if (above_rom) begin
      // Leaving ROM drops privilege and wins over entry hits
      system_mode    <= 1'b1;
      rom_executable <= 1'b0;
      rw_locked      <= 1'b1;
    end else begin
      if (hit_syscall) begin
        system_mode <= 1'b0;
      end
      if (rom_entry) begin
        rom_executable <= 1'b1;
      end
    end
  end

endmodule

//--- hdl/tk1_regs.sv
`timescale 1ns/1ps

module tk1_regs (
  input  logic                clk,
  input  logic                reset_n,

  input  logic                cs,
  input  logic                we,
  input  tk1_pkg::reg_addr_t  address,
  input  tk1_pkg::word_t      write_data,

  input  logic                system_mode,
  input  logic                rw_locked,

  input  logic                gpio1,
  input  logic                gpio2,

  output tk1_pkg::word_t      read_data,
  output logic                ready,

  output tk1_pkg::led_t       led_sw,
  output logic                gpio3,
  output logic                gpio4,
  output logic                system_reset,

  output tk1_pkg::cpu_addr_t  syscall_addr,
  output tk1_pkg::cpu_addr_t  blake2s_addr,

  output logic                cpu_mon_en,
  output tk1_pkg::cpu_addr_t  cpu_mon_first,
  output tk1_pkg::cpu_addr_t  cpu_mon_last
);

  import tk1_pkg::*;

  word_t      app_start;
  word_t      app_size;
  word_t      cdi_mem [8];

  logic [1:0] gpio1_sync;
  logic [1:0] gpio2_sync;

  logic       wr_en;
  logic       prot_wr_en;
  logic       mon_wr_en;
  logic       cdi_hit;

  // --------------------
  // Write qualification
  // --------------------

  assign wr_en      = cs && we;
  // Locked once system mode has been entered
  assign prot_wr_en = wr_en && !rw_locked;
  // Window is frozen after enable
  assign mon_wr_en  = wr_en && !cpu_mon_en;

  assign cdi_hit    = (address >= ADDR_CDI_FIRST) && (address <= ADDR_CDI_LAST);

  // No wait states
  assign ready = cs;

  // --------------------
  // Control registers
  // --------------------

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      led_sw       <= LED_RESET;
      gpio3        <= 1'b0;
      gpio4        <= 1'b0;
      gpio1_sync   <= 2'b00;
      gpio2_sync   <= 2'b00;
      system_reset <= 1'b0;
      app_start    <= '0;
      app_size     <= APP_SIZE_RESET;
      syscall_addr <= ILLEGAL_ADDR;
      blake2s_addr <= ILLEGAL_ADDR;
      cpu_mon_en   <= 1'b0;
    end else begin
      gpio1_sync <= {gpio1_sync[0], gpio1};
      gpio2_sync <= {gpio2_sync[0], gpio2};

      // One-cycle strobe per write
      system_reset <= wr_en && (address == ADDR_SYSTEM_RESET);

      if (wr_en && (address == ADDR_LED)) begin
        led_sw <= write_data[2:0];
      end

      if (wr_en && (address == ADDR_GPIO)) begin
        gpio3 <= write_data[GPIO3_BIT];
        gpio4 <= write_data[GPIO4_BIT];
      end

      if (prot_wr_en) begin
        case (address)
          ADDR_APP_START: app_start    <= write_data;
          ADDR_APP_SIZE:  app_size     <= write_data;
          ADDR_SYSCALL:   syscall_addr <= write_data;
          ADDR_BLAKE2S:   blake2s_addr <= write_data;
          default: ;
        endcase
      end

      // Any write enables the monitor, and it stays on until reset
      if (wr_en && (address == ADDR_CPU_MON_CTRL)) begin
        cpu_mon_en <= 1'b1;
      end
    end
  end

  // CDI words and monitor window
  always_ff @(posedge clk) begin
    if (prot_wr_en && cdi_hit) begin
      cdi_mem[address[2:0]] <= write_data;
    end

    if (mon_wr_en && (address == ADDR_CPU_MON_FIRST)) begin
      cpu_mon_first <= write_data;
    end

    if (mon_wr_en && (address == ADDR_CPU_MON_LAST)) begin
      cpu_mon_last <= write_data;
    end
  end

  // --------------------
  // Read mux
  // --------------------

  always_comb begin
    read_data = '0;
    if (cs && !we) begin
      case (address) inside
        ADDR_NAME0:            read_data = TK1_NAME0;
        ADDR_NAME1:            read_data = TK1_NAME1;
        ADDR_VERSION:          read_data = TK1_VERSION;
        ADDR_SYSTEM_MODE_CTRL: read_data = {32{system_mode}};
        ADDR_LED:              read_data = {29'h0, led_sw};
        ADDR_GPIO: begin
          read_data = {28'h0, gpio4, gpio3, gpio2_sync[1], gpio1_sync[1]};
        end
        ADDR_APP_START:        read_data = app_start;
        ADDR_APP_SIZE:         read_data = app_size;
        ADDR_BLAKE2S:          read_data = blake2s_addr;
        ADDR_SYSCALL:          read_data = syscall_addr;
        ADDR_CPU_MON_CTRL:     read_data = {31'h0, cpu_mon_en};
        ADDR_CPU_MON_FIRST:    read_data = cpu_mon_first;
        ADDR_CPU_MON_LAST:     read_data = cpu_mon_last;
        [ADDR_CDI_FIRST:ADDR_CDI_LAST]: begin
          read_data = cdi_mem[address[2:0]];
        end
        default:               read_data = '0;
      endcase
    end
  end

endmodule

//--- hdl/tk1_pkg.sv
package tk1_pkg;

  // --------------------
  // Shared types
  // --------------------

  typedef logic [31:0] cpu_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0] reg_addr_t;

  // Bit 2 red, bit 1 green, bit 0 blue
  typedef logic [2:0] led_t;

  typedef logic [23:0] blink_ctr_t;

  // --------------------
  // Register map
  // --------------------

  localparam reg_addr_t ADDR_NAME0            = 8'h00;
  localparam reg_addr_t ADDR_NAME1            = 8'h01;
  localparam reg_addr_t ADDR_VERSION          = 8'h02;

  localparam reg_addr_t ADDR_SYSTEM_MODE_CTRL = 8'h08;
  localparam reg_addr_t ADDR_LED              = 8'h09;
  localparam reg_addr_t ADDR_GPIO             = 8'h0a;

  localparam reg_addr_t ADDR_APP_START        = 8'h0c;
  localparam reg_addr_t ADDR_APP_SIZE         = 8'h0d;

  // Firmware entry points
  localparam reg_addr_t ADDR_BLAKE2S          = 8'h10;
  localparam reg_addr_t ADDR_SYSCALL          = 8'h12;

  // Eight words of CDI
  localparam reg_addr_t ADDR_CDI_FIRST        = 8'h20;
  localparam reg_addr_t ADDR_CDI_LAST         = 8'h27;

  localparam reg_addr_t ADDR_CPU_MON_CTRL     = 8'h60;
  localparam reg_addr_t ADDR_CPU_MON_FIRST    = 8'h61;
  localparam reg_addr_t ADDR_CPU_MON_LAST     = 8'h62;

  localparam reg_addr_t ADDR_SYSTEM_RESET     = 8'h70;

  // --------------------
  // Identity and limits
  // --------------------

  // ASCII "tk1 " and "mkdf"
  localparam word_t TK1_NAME0   = 32'h746b3120;
  localparam word_t TK1_NAME1   = 32'h6d6b6466;
  localparam word_t TK1_VERSION = 32'h00000005;

  localparam cpu_addr_t FW_RAM_FIRST = 32'hd0000000;
  localparam cpu_addr_t FW_RAM_LAST  = 32'hd00007ff;

  // ROM starts at address zero
  localparam cpu_addr_t FW_ROM_LAST  = 32'h00001fff;

  // Lies beyond physical RAM, so a fetch there traps
  localparam cpu_addr_t ILLEGAL_ADDR = 32'h4f000000;

  // Output bits in the GPIO register
  localparam int GPIO3_BIT = 2;
  localparam int GPIO4_BIT = 3;

  localparam led_t LED_RESET       = 3'b110;
  localparam word_t APP_SIZE_RESET = 32'h00000000;

endpackage
